//--- flist.f
hdl/pin_harness_pkg.sv
hdl/i2c_bus_bank.sv
hdl/loopback_retimer.sv
hdl/cheri_err_tracker.sv
hdl/board_pin_harness.sv
verification/tb_board_pin_harness.sv

//--- hdl/board_pin_harness.sv
// ------------------------------------------------
// Board pin harness.
// Joins I2C bus resolution, loopback retiming and
// CHERI error tracking onto the flat pin vectors.
// ------------------------------------------------

module board_pin_harness import pin_harness_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Pin vectors from the system.
  input  logic [InoutPinW-1:0] inout_to_pins_i,
  input  logic [InoutPinW-1:0] inout_to_pins_en_i,
  input  logic [OutPinW-1:0]   out_to_pins_i,
  // Pin vectors back to the system.
  output logic [InoutPinW-1:0] inout_from_pins_o,
  output logic [InPinW-1:0]    in_from_pins_o,
  // I2C device models.
  input  i2c_lines_vec_t       i2c_dev_i,
  output i2c_lines_vec_t       i2c_bus_o,
  // CHERI error reporting.
  input  logic [CheriErrW-1:0] cheri_err_i,
  output logic [CheriErrW-1:0] cheri_seen_o,
  output logic                 cheri_new_o,
  output logic [CheriIdxW-1:0] cheri_new_idx_o
);

  // Resolved I2C pin levels.
  logic [InoutPinW-1:0] i2c_from_pins;
  // Retimed inout returns, TMPIO9 then TMPIO0.
  logic [1:0]           loop_inout;

  // I2C buses, combinational.
  i2c_bus_bank u_i2c_bus_bank (
    .inout_to_pins_i    (inout_to_pins_i),
    .inout_to_pins_en_i (inout_to_pins_en_i),
    .i2c_dev_i          (i2c_dev_i),
    .i2c_bus_o          (i2c_bus_o),
    .i2c_from_pins_o    (i2c_from_pins)
  );

  // Loopback pairs, one cycle late.
  loopback_retimer u_loopback_retimer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .inout_to_pins_i (inout_to_pins_i),
    .out_to_pins_i   (out_to_pins_i),
    .loop_inout_o    (loop_inout),
    .in_from_pins_o  (in_from_pins_o)
  );

  // CHERI first-occurrence tracking.
  cheri_err_tracker u_cheri_err_tracker (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cheri_err_i     (cheri_err_i),
    .cheri_seen_o    (cheri_seen_o),
    .cheri_new_o     (cheri_new_o),
    .cheri_new_idx_o (cheri_new_idx_o)
  );

  // Merge sources into the inout return vector.
  always_comb begin
    // Unconnected pins idle high.
    inout_from_pins_o = '1;

    // Modelled buses.
    for (int b = 0; b < NumI2cBuses; b++) begin
      inout_from_pins_o[I2C_SCL_PIN[b]] = i2c_from_pins[I2C_SCL_PIN[b]];
      inout_from_pins_o[I2C_SDA_PIN[b]] = i2c_from_pins[I2C_SDA_PIN[b]];
    end

    // Pulled-up buses.
    for (int p = 0; p < NumI2cPullups; p++) begin
      inout_from_pins_o[I2C_PULLUP_PINS[p]] = i2c_from_pins[I2C_PULLUP_PINS[p]];
    end

    // Arduino loopbacks.
    inout_from_pins_o[INOUT_PIN_AH_TMPIO9] = loop_inout[1];
    inout_from_pins_o[INOUT_PIN_AH_TMPIO0] = loop_inout[0];
  end

endmodule

//--- hdl/cheri_err_tracker.sv
// ------------------------------------------------
// CHERI error tracker.
// Sticky record of error classes with a one-cycle
// strobe carrying the lowest newly seen class.
// ------------------------------------------------

module cheri_err_tracker import pin_harness_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Modulated error levels, one bit per class.
  input  logic [CheriErrW-1:0] cheri_err_i,
  // Classes seen since reset.
  output logic [CheriErrW-1:0] cheri_seen_o,
  // First-occurrence strobe and class index.
  output logic                 cheri_new_o,
  output logic [CheriIdxW-1:0] cheri_new_idx_o
);

  logic [CheriErrW-1:0] seen_q;
  logic [CheriErrW-1:0] new_cls;
  logic                 any_new;
  logic                 new_q;
  logic [CheriIdxW-1:0] new_idx_d;
  logic [CheriIdxW-1:0] new_idx_q;

  // Classes high now but not yet recorded.
  // Error lines pulse many times per event,
  // so only the first pulse counts.
  assign new_cls = cheri_err_i & ~seen_q;
  assign any_new = |new_cls;

  // Lowest set bit wins.
  // Scan from the top so lower bits overwrite.
  always_comb begin
    new_idx_d = '0;
    for (int i = CheriErrW - 1; i >= 0; i--) begin
      if (new_cls[i]) begin
        new_idx_d = CheriIdxW'(i);
      end
    end
  end

  // Seen vector only ever gains bits.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_q <= '0;
    end else if (any_new) begin
      seen_q <= seen_q | cheri_err_i;
    end
  end

  // Strobe lasts one cycle per batch of new classes.
  // Index holds until the next batch.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      new_q     <= 1'b0;
      new_idx_q <= '0;
    end else begin
      new_q <= any_new;
      if (any_new) begin
        new_idx_q <= new_idx_d;
      end
    end
  end

  assign cheri_seen_o    = seen_q;
  assign cheri_new_o     = new_q;
  assign cheri_new_idx_o = new_idx_q;

  // Strobe drops after one cycle unless fresh classes arrive.
  property p_new_single;
    @(posedge clk_i) disable iff (!rst_ni)
      (cheri_new_o && !any_new) |=> !cheri_new_o;
  endproperty
  a_new_single: assert property (p_new_single)
    else $error("cheri_new_o held without a new class");

  // Recorded classes stay recorded until reset.
  property p_seen_sticky;
    @(posedge clk_i) disable iff (!rst_ni)
      (cheri_seen_o & $past(cheri_seen_o)) == $past(cheri_seen_o);
  endproperty
  a_seen_sticky: assert property (p_seen_sticky)
    else $error("cheri_seen_o lost a bit outside reset");

endmodule

//--- hdl/i2c_bus_bank.sv
// ------------------------------------------------
// I2C bus bank.
// Open-drain wired-AND resolution of the modelled
// I2C buses and pull-ups on the unmodelled pins.
// ------------------------------------------------

module i2c_bus_bank import pin_harness_pkg::*; (
  // Controller side of the inout pins.
  input  logic [InoutPinW-1:0] inout_to_pins_i,
  input  logic [InoutPinW-1:0] inout_to_pins_en_i,
  // Device pull-downs, one pair per bus.
  input  i2c_lines_vec_t       i2c_dev_i,
  // Controller open-drain level, one pair per bus.
  output i2c_lines_vec_t       i2c_bus_o,
  // Resolved levels at the I2C pin positions.
  output logic [InoutPinW-1:0] i2c_from_pins_o
);

  // Wired-AND of controller and device on each line.
  i2c_lines_vec_t line_lvl;

  for (genvar b = 0; b < NumI2cBuses; b++) begin : g_bus

    // An open-drain driver only pulls low.
    // Released lines float to 1.
    assign i2c_bus_o[b] = '{
      scl: inout_to_pins_en_i[I2C_SCL_PIN[b]] ? inout_to_pins_i[I2C_SCL_PIN[b]] : 1'b1,
      sda: inout_to_pins_en_i[I2C_SDA_PIN[b]] ? inout_to_pins_i[I2C_SDA_PIN[b]] : 1'b1
    };

    // Bus is low if either side pulls it low.
    // The controller must see its own traffic here
    // or it reports contention.
    assign line_lvl[b] = i2c_bus_o[b] & i2c_dev_i[b];

    // A driven 0 always wins on the returned pin.
    always_comb begin : p_od_check
      assert (!(inout_to_pins_en_i[I2C_SCL_PIN[b]] === 1'b1 &&
                inout_to_pins_i[I2C_SCL_PIN[b]] === 1'b0 &&
                i2c_from_pins_o[I2C_SCL_PIN[b]] === 1'b1))
        else $error("I2C bus %0d: SCL high while driven low", b);
      assert (!(inout_to_pins_en_i[I2C_SDA_PIN[b]] === 1'b1 &&
                inout_to_pins_i[I2C_SDA_PIN[b]] === 1'b0 &&
                i2c_from_pins_o[I2C_SDA_PIN[b]] === 1'b1))
        else $error("I2C bus %0d: SDA high while driven low", b);
    end

  end

  // Scatter resolved lines back to pin positions.
  always_comb begin
    // Non-I2C positions carry nothing here.
    i2c_from_pins_o = '0;

    // Unmodelled buses idle high.
    // Only the PCB pull-up is present.
    for (int p = 0; p < NumI2cPullups; p++) begin
      i2c_from_pins_o[I2C_PULLUP_PINS[p]] = 1'b1;
    end

    // Modelled buses return the resolved level.
    for (int b = 0; b < NumI2cBuses; b++) begin
      i2c_from_pins_o[I2C_SCL_PIN[b]] = line_lvl[b].scl;
      i2c_from_pins_o[I2C_SDA_PIN[b]] = line_lvl[b].sda;
    end
  end

endmodule

//--- hdl/loopback_retimer.sv
// ------------------------------------------------
// Loopback retimer.
// One register stage returning loopback outputs
// to their paired input pins.
// ------------------------------------------------

module loopback_retimer import pin_harness_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Loopback sources.
  input  logic [InoutPinW-1:0] inout_to_pins_i,
  input  logic [OutPinW-1:0]   out_to_pins_i,
  // Returned inout bits, TMPIO9 then TMPIO0.
  output logic [1:0]           loop_inout_o,
  // Returned input pins.
  output logic [InPinW-1:0]    in_from_pins_o
);

  // One field per returned pin.
  typedef struct packed {
    logic tmpio9;
    logic tmpio0;
    logic mb8;
    logic mb3;
  } loop_bits_t;

  loop_bits_t loop_q;

  // Registering the return breaks the loop
  // between the pin vectors.
  // A plain wire would close a combinational cycle at net level.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loop_q <= '0;
    end else begin
      loop_q.tmpio9 <= inout_to_pins_i[INOUT_PIN_AH_TMPIO8];
      loop_q.tmpio0 <= inout_to_pins_i[INOUT_PIN_AH_TMPIO1];
      // mikroBUS UART TX to RX.
      loop_q.mb8    <= out_to_pins_i[OUT_PIN_MB7];
      // mikroBUS SPI COPI to CIPO.
      loop_q.mb3    <= out_to_pins_i[OUT_PIN_MB4];
    end
  end

  assign loop_inout_o = {loop_q.tmpio9, loop_q.tmpio0};

  // Place returns at their input pin positions.
  always_comb begin
    in_from_pins_o             = '0;
    in_from_pins_o[IN_PIN_MB8] = loop_q.mb8;
    in_from_pins_o[IN_PIN_MB3] = loop_q.mb3;
  end

endmodule

//--- hdl/pin_harness_pkg.sv
// ------------------------------------------------
// Pin harness package.
// Pin widths, pin indices, I2C bus tables and the
// I2C line structs shared by the harness blocks.
// ------------------------------------------------

package pin_harness_pkg;

  // Widths of the flat pin vectors.
  localparam int InPinW    = 2;
  localparam int OutPinW   = 2;
  localparam int InoutPinW = 14;

  // Inout pin positions.
  // QWIIC0 / Arduino I2C pair, no device model.
  localparam int INOUT_PIN_SCL0       = 0;
  localparam int INOUT_PIN_SDA0       = 1;
  // QWIIC1 I2C pair.
  localparam int INOUT_PIN_SCL1       = 2;
  localparam int INOUT_PIN_SDA1       = 3;
  // RPi HAT ID EEPROM bus (G1 is SCL, G0 is SDA).
  localparam int INOUT_PIN_RPH_G0     = 4;
  localparam int INOUT_PIN_RPH_G1     = 5;
  // RPi HAT secondary bus, shared with GPIO2/3.
  localparam int INOUT_PIN_RPH_G2_SDA = 6;
  localparam int INOUT_PIN_RPH_G3_SCL = 7;
  // mikroBUS Click I2C pair, no device model.
  localparam int INOUT_PIN_MB5        = 8;
  localparam int INOUT_PIN_MB6        = 9;
  // Arduino loopback pairs.
  localparam int INOUT_PIN_AH_TMPIO0  = 10;
  localparam int INOUT_PIN_AH_TMPIO1  = 11;
  localparam int INOUT_PIN_AH_TMPIO8  = 12;
  localparam int INOUT_PIN_AH_TMPIO9  = 13;

  // Output pin positions.
  // MB4 is SPI COPI, MB7 is UART TX.
  localparam int OUT_PIN_MB4 = 0;
  localparam int OUT_PIN_MB7 = 1;

  // Input pin positions.
  // MB3 is SPI CIPO, MB8 is UART RX.
  localparam int IN_PIN_MB3 = 0;
  localparam int IN_PIN_MB8 = 1;

  // Modelled I2C buses.
  // Order is rpi0, rpi1, qwiic1.
  localparam int NumI2cBuses = 3;

  // Clock and data pin of each modelled bus.
  localparam int I2C_SCL_PIN [NumI2cBuses] = '{
    INOUT_PIN_RPH_G1, INOUT_PIN_RPH_G3_SCL, INOUT_PIN_SCL1
  };
  localparam int I2C_SDA_PIN [NumI2cBuses] = '{
    INOUT_PIN_RPH_G0, INOUT_PIN_RPH_G2_SDA, INOUT_PIN_SDA1
  };

  // I2C pins without a model.
  // These only see the board pull-ups.
  localparam int NumI2cPullups = 4;
  localparam int I2C_PULLUP_PINS [NumI2cPullups] = '{
    INOUT_PIN_SCL0, INOUT_PIN_SDA0, INOUT_PIN_MB5, INOUT_PIN_MB6
  };

  // CHERI error classes, bit 0 first.
  // Bounds, Tag, Seal, Permit Execute, Permit Load, Permit Store,
  // Permit Store Cap, Permit Store Local Cap, Permit Acc Sys Regs.
  localparam int CheriErrW = 9;
  localparam int CheriIdxW = 4;

  // One pair of open-drain I2C lines.
  typedef struct packed {
    logic scl;
    logic sda;
  } i2c_lines_t;

  // Line pairs for all modelled buses.
  typedef i2c_lines_t [NumI2cBuses-1:0] i2c_lines_vec_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# Build and run the board pin harness testbench with Verilator.
# The run counts as failed when the log holds the fail message.

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_board_pin_harness -f flist.f -o tb_board_pin_harness \
  > "$log" 2>&1 \
  && ./obj_dir/tb_board_pin_harness >> "$log" 2>&1 \
  || echo "Some tests failed" >> "$log"

cat "$log"

grep -q "Some tests failed" "$log" && exit 1 || exit 0

//--- verification/tb_board_pin_harness.sv
// ------------------------------------------------
// Board pin harness testbench.
// Random pin traffic and CHERI error pulses, checked
// by concurrent assertions against reference models.
// ------------------------------------------------

module tb_board_pin_harness import pin_harness_pkg::*;;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ClkPeriod       = 20;
  localparam int ResetCycles     = 2;
  localparam int NumRandCycles   = 200;
  localparam int NumSingleRounds = 12;
  localparam int NumMultiRounds  = 4;
  localparam int Seed            = 32'h37e8ea8e;
  // Upper bound on stimulus cycles, used by the watchdog.
  localparam int TotalCycles = ResetCycles + NumRandCycles + 6 * NumSingleRounds +
                               (ResetCycles + 5) * NumMultiRounds +
                               2 * (ResetCycles + 2) + 6;
  localparam int TimeoutNs   = TotalCycles * ClkPeriod + 500;
  // Inout positions fed by the retimer.
  localparam logic [InoutPinW-1:0] RetMask =
    (InoutPinW'(1) << INOUT_PIN_AH_TMPIO0) | (InoutPinW'(1) << INOUT_PIN_AH_TMPIO9);

  // Four loopback pairs, source and return side.
  typedef struct packed {
    logic tmpio9;
    logic tmpio0;
    logic mb8;
    logic mb3;
  } loop_bits_t;

  logic                 clk_i;
  logic                 rst_ni;
  logic [InoutPinW-1:0] inout_to_pins;
  logic [InoutPinW-1:0] inout_to_pins_en;
  logic [OutPinW-1:0]   out_to_pins;
  logic [InoutPinW-1:0] inout_from_pins;
  logic [InPinW-1:0]    in_from_pins;
  i2c_lines_vec_t       i2c_dev;
  i2c_lines_vec_t       i2c_bus;
  logic [CheriErrW-1:0] cheri_err;
  logic [CheriErrW-1:0] cheri_seen;
  logic                 cheri_new;
  logic [CheriIdxW-1:0] cheri_new_idx;

  // Expected values.
  i2c_lines_vec_t       exp_bus;
  logic [InoutPinW-1:0] exp_from;
  logic [CheriErrW-1:0] fresh;
  logic [CheriErrW-1:0] exp_seen;
  logic                 exp_new;
  logic [CheriIdxW-1:0] exp_idx;
  loop_bits_t           loop_src;
  loop_bits_t           loop_ret;

  board_pin_harness u_dut (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .inout_to_pins_i    (inout_to_pins),
    .inout_to_pins_en_i (inout_to_pins_en),
    .out_to_pins_i      (out_to_pins),
    .inout_from_pins_o  (inout_from_pins),
    .in_from_pins_o     (in_from_pins),
    .i2c_dev_i          (i2c_dev),
    .i2c_bus_o          (i2c_bus),
    .cheri_err_i        (cheri_err),
    .cheri_seen_o       (cheri_seen),
    .cheri_new_o        (cheri_new),
    .cheri_new_idx_o    (cheri_new_idx)
  );

  initial clk_i = 1'b0;
  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // Prints the error line and the fail message, then stops.
  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1);
  endtask

  // Lowest set bit, scanned upward.
  function automatic logic [CheriIdxW-1:0] lowest_index(input logic [CheriErrW-1:0] cls);
    logic [CheriIdxW-1:0] idx;
    logic                 found;
    idx   = '0;
    found = 1'b0;
    for (int i = 0; i < CheriErrW; i++) begin
      if (cls[i] && !found) begin
        idx   = CheriIdxW'(i);
        found = 1'b1;
      end
    end
    return idx;
  endfunction

  // Open-drain controller level, then wired-AND with the device.
  always_comb begin : p_i2c_model
    exp_bus  = '0;
    exp_from = '1;
    for (int b = 0; b < NumI2cBuses; b++) begin
      exp_bus[b].scl = inout_to_pins_en[I2C_SCL_PIN[b]] ? inout_to_pins[I2C_SCL_PIN[b]] : 1'b1;
      exp_bus[b].sda = inout_to_pins_en[I2C_SDA_PIN[b]] ? inout_to_pins[I2C_SDA_PIN[b]] : 1'b1;
      exp_from[I2C_SCL_PIN[b]] = exp_bus[b].scl & i2c_dev[b].scl;
      exp_from[I2C_SDA_PIN[b]] = exp_bus[b].sda & i2c_dev[b].sda;
    end
  end

  assign loop_src = '{tmpio9: inout_to_pins[INOUT_PIN_AH_TMPIO8],
                      tmpio0: inout_to_pins[INOUT_PIN_AH_TMPIO1],
                      mb8:    out_to_pins[OUT_PIN_MB7],
                      mb3:    out_to_pins[OUT_PIN_MB4]};
  assign loop_ret = '{tmpio9: inout_from_pins[INOUT_PIN_AH_TMPIO9],
                      tmpio0: inout_from_pins[INOUT_PIN_AH_TMPIO0],
                      mb8:    in_from_pins[IN_PIN_MB8],
                      mb3:    in_from_pins[IN_PIN_MB3]};

  // First-occurrence model of the CHERI classes.
  assign fresh = cheri_err & ~exp_seen;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cheri_model
    if (!rst_ni) begin
      exp_seen <= '0;
      exp_new  <= 1'b0;
      exp_idx  <= '0;
    end else begin
      exp_new <= |fresh;
      if (|fresh) begin
        exp_seen <= exp_seen | fresh;
        exp_idx  <= lowest_index(fresh);
      end
    end
  end

  // Checks run on the falling edge, where all signals are settled.
  a_i2c_bus: assert property (@(negedge clk_i) i2c_bus == exp_bus)
    else abort_run($sformatf("Fail: i2c_bus_o expected %h got %h", exp_bus, i2c_bus));
  a_i2c_pins: assert property (@(negedge clk_i)
    (inout_from_pins & ~RetMask) == (exp_from & ~RetMask))
    else abort_run($sformatf("Fail: inout_from_pins_o expected %h got %h",
                             exp_from & ~RetMask, inout_from_pins & ~RetMask));
  a_loopback: assert property (@(negedge clk_i)
    (rst_ni && $past(rst_ni)) |-> loop_ret == $past(loop_src))
    else abort_run($sformatf("Fail: loopback returns expected %h got %h",
                             $past(loop_src), loop_ret));
  a_reset_state: assert property (@(negedge clk_i)
    (!rst_ni || !$past(rst_ni)) |->
      (loop_ret == '0 && cheri_seen == '0 && !cheri_new && cheri_new_idx == '0))
    else abort_run($sformatf("Fail: reset state loop %h seen %h new %h idx %h, expected 0",
                             loop_ret, cheri_seen, cheri_new, cheri_new_idx));
  a_cheri_seen: assert property (@(negedge clk_i) cheri_seen == exp_seen)
    else abort_run($sformatf("Fail: cheri_seen_o expected %h got %h", exp_seen, cheri_seen));
  a_cheri_new: assert property (@(negedge clk_i) cheri_new == exp_new)
    else abort_run($sformatf("Fail: cheri_new_o expected %h got %h", exp_new, cheri_new));
  a_cheri_idx: assert property (@(negedge clk_i) exp_new |-> cheri_new_idx == exp_idx)
    else abort_run($sformatf("Fail: cheri_new_idx_o expected %h got %h",
                             exp_idx, cheri_new_idx));

  // One cycle of random pin traffic with a given error level.
  task automatic drive_cycle(input logic [CheriErrW-1:0] err);
    logic [31:0] rnd;
    @(posedge clk_i);
    #2;
    inout_to_pins    = InoutPinW'($urandom);
    inout_to_pins_en = InoutPinW'($urandom);
    out_to_pins      = OutPinW'($urandom);
    rnd              = $urandom;
    i2c_dev          = rnd[$bits(i2c_lines_vec_t)-1:0];
    cheri_err        = err;
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    #2;
    rst_ni = 1'b0;
    repeat (ResetCycles) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
  endtask

  initial begin : p_stimulus
    logic [31:0]          rnd;
    logic [CheriErrW-1:0] mask;
    int                   cls;
    rst_ni           = 1'b0;
    inout_to_pins    = '0;
    inout_to_pins_en = '0;
    out_to_pins      = '0;
    i2c_dev          = '0;
    cheri_err        = '0;
    rnd              = $urandom(Seed);
    cls              = 0;
    repeat (ResetCycles) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // Random I2C and loopback traffic.
    repeat (NumRandCycles) drive_cycle('0);

    // One class at a time, each pulsed twice.
    repeat (NumSingleRounds) begin
      cls       = $urandom_range(CheriErrW - 1);
      mask      = '0;
      mask[cls] = 1'b1;
      repeat (2) begin
        drive_cycle(mask);
        drive_cycle('0);
        drive_cycle('0);
      end
    end

    // Several fresh classes together, at least two.
    repeat (NumMultiRounds) begin
      apply_reset();
      rnd                 = $urandom;
      mask                = rnd[CheriErrW-1:0];
      mask[CheriErrW-1]   = 1'b1;
      mask[$urandom_range(CheriErrW - 2)] = 1'b1;
      drive_cycle(mask);
      repeat (3) drive_cycle('0);
    end

    // Reset lands on a live strobe.
    // The class seen before reset strobes again after it.
    apply_reset();
    mask      = '0;
    mask[cls] = 1'b1;
    drive_cycle(mask);
    apply_reset();
    drive_cycle(mask);
    repeat (2) drive_cycle('0);

    repeat (4) @(posedge clk_i);
    $display("All tests passed");
    $finish;
  end

  initial begin : p_watchdog
    #(TimeoutNs);
    abort_run("Timeout: the run did not reach its end in the expected time");
  end

endmodule
